// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = md_tb
FILELIST = vlog.f
OBJ_DIR  = obj_dir
LOG      = sim.log
PASS_MSG = Verification passed

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bench/md_checker.sv
`timescale 1ns/1ps

module md_checker #(
    parameter int RS_DEPTH = 8,
    parameter int TOP_W    = $clog2(RS_DEPTH + 1),
    parameter int RS_IDX   = (RS_DEPTH > 1) ? $clog2(RS_DEPTH) : 1
) (
    input logic              clk,
    input logic              rst,
    input logic              ds_ready,
    input logic [TOP_W-1:0]  rs_top,
    input logic              iss_valid,
    input logic [RS_IDX-1:0] issue_idx,
    input logic              src1_rdy [RS_DEPTH],
    input logic              src2_rdy [RS_DEPTH]
);

    a_quiet_in_reset: assert property (@(posedge clk) rst && $past(rst) |-> !iss_valid)
        else $error("station requests issue during reset");

    // with ds_ready low nothing is pushed or popped, so occupancy holds
    a_no_push_when_full: assert property (@(posedge clk) disable iff (rst)
        !ds_ready |=> rs_top == $past(rs_top))
        else $error("station occupancy changes while ds_ready is low");

    a_top_in_range: assert property (@(posedge clk) disable iff (rst)
        rs_top <= TOP_W'(RS_DEPTH))
        else $error("station occupancy above RS_DEPTH");

    a_issue_operands_ready: assert property (@(posedge clk) disable iff (rst)
        iss_valid |-> src1_rdy[issue_idx] && src2_rdy[issue_idx])
        else $error("issued entry has an operand that is not ready");

endmodule

// File: bench/md_tb.sv
`timescale 1ns/1ps

module md_tb;
    import md_pkg::*;

    localparam int DEPTH        = 8;
    localparam int PERIOD_NS    = 40;
    localparam int RESET_CYCLES = 16;
    // operations over all tests, each allowed a full divide
    localparam int N_OPS        = 10 + DEPTH + 3;
    localparam int DIV_CYCLES   = 36;
    localparam int WATCHDOG_NS  = (RESET_CYCLES + N_OPS * DIV_CYCLES + 500) * PERIOD_NS;

    logic               clk;
    logic               rst;
    logic               in_valid;
    logic               in_ready;
    md_op_t             in_op;
    logic [PHY_IDX-1:0] in_rs1_phy, in_rs2_phy, in_rd_phy;
    logic [ROB_IDX-1:0] in_rob_id;
    logic               wb_valid;
    logic [PHY_IDX-1:0] wb_phy;
    logic [XLEN-1:0]    wb_value;
    logic               cdb_valid;
    logic [PHY_IDX-1:0] cdb_phy;
    logic [ROB_IDX-1:0] cdb_rob_id;
    logic [XLEN-1:0]    cdb_value;

    logic [XLEN-1:0]    model_regs [PHY_REGS];
    logic [ROB_IDX-1:0] exp_rob [$];
    logic [PHY_IDX-1:0] exp_phy [$];
    logic [XLEN-1:0]    exp_val [$];
    logic [ROB_IDX-1:0] res_rob [$];
    logic [PHY_IDX-1:0] res_phy [$];
    logic [XLEN-1:0]    res_val [$];
    logic [31:0]        lcg_state;
    logic               stall_seen;
    int                 err_count;
    int                 check_count;
    int                 test_count;
    int                 test_err_base;

    md_core #(.RS_DEPTH(DEPTH)) dut_i (.*);

    bind md_rs md_checker #(.RS_DEPTH(RS_DEPTH)) checker_i (
        .clk        (clk),
        .rst        (rst),
        .ds_ready   (ds_ready),
        .rs_top     (rs_top),
        .iss_valid  (iss_valid),
        .issue_idx  (issue_idx),
        .src1_rdy   (src1_rdy),
        .src2_rdy   (src2_rdy)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2);
            clk = ~clk;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before all results were broadcast");
        $display("Verification failed");
        $finish;
    end

    // collect every cdb slot 1 broadcast
    always @(negedge clk) begin
        if (!rst && cdb_valid) begin
            res_rob.push_back(cdb_rob_id);
            res_phy.push_back(cdb_phy);
            res_val.push_back(cdb_value);
        end
    end

    // ----------------------------------------
    // reference model and helpers
    // ----------------------------------------
    function automatic logic [XLEN-1:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic logic [XLEN-1:0] expected_result(input md_op_t op,
                                                        input logic [XLEN-1:0] a,
                                                        input logic [XLEN-1:0] b);
        logic [2*XLEN-1:0] full;
        full = {{XLEN{1'b0}}, a} * {{XLEN{1'b0}}, b};
        case (op)
            MUL:     return full[XLEN-1:0];
            MULHU:   return full[2*XLEN-1:XLEN];
            DIVU:    return (b == '0) ? '1 : a / b;
            default: return (b == '0) ? a : a % b;
        endcase
    endfunction

    task automatic check_value(input string what, input logic [XLEN-1:0] got,
                               input logic [XLEN-1:0] expected);
        check_count++;
        if (got !== expected) begin
            err_count++;
            $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, expected);
        end
    endtask

    task automatic write_reg(input logic [PHY_IDX-1:0] phy, input logic [XLEN-1:0] value);
        wb_valid = 1'b1;
        wb_phy   = phy;
        wb_value = value;
        model_regs[phy] = value;
        @(posedge clk);
        #2;
        wb_valid = 1'b0;
    endtask

    task automatic predict(input md_op_t op, input logic [PHY_IDX-1:0] rs1,
                           input logic [PHY_IDX-1:0] rs2, input logic [PHY_IDX-1:0] rd,
                           input logic [ROB_IDX-1:0] rob);
        logic [XLEN-1:0] result;
        result = expected_result(op, model_regs[rs1], model_regs[rs2]);
        model_regs[rd] = result;
        exp_rob.push_back(rob);
        exp_phy.push_back(rd);
        exp_val.push_back(result);
    endtask

    // hold the micro-op until in_ready is seen before an edge
    task automatic dispatch_op(input md_op_t op, input logic [PHY_IDX-1:0] rs1,
                               input logic [PHY_IDX-1:0] rs2, input logic [PHY_IDX-1:0] rd,
                               input logic [ROB_IDX-1:0] rob);
        logic accepted;
        in_valid   = 1'b1;
        in_op      = op;
        in_rs1_phy = rs1;
        in_rs2_phy = rs2;
        in_rd_phy  = rd;
        in_rob_id  = rob;
        accepted   = 1'b0;
        while (!accepted) begin
            @(negedge clk);
            accepted = in_ready;
            if (!accepted) begin
                stall_seen = 1'b1;
            end
            @(posedge clk);
            #2;
        end
        in_valid = 1'b0;
    endtask

    task automatic issue_op(input md_op_t op, input logic [PHY_IDX-1:0] rs1,
                            input logic [PHY_IDX-1:0] rs2, input logic [PHY_IDX-1:0] rd,
                            input logic [ROB_IDX-1:0] rob);
        predict(op, rs1, rs2, rd, rob);
        dispatch_op(op, rs1, rs2, rd, rob);
    endtask

    // results must come back in the order they were predicted
    task automatic drain_results();
        while (res_rob.size() < exp_rob.size()) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);
        check_value("result count", XLEN'(res_rob.size()), XLEN'(exp_rob.size()));
        while (exp_rob.size() > 0 && res_rob.size() > 0) begin
            check_value("cdb_rob_id", XLEN'(res_rob.pop_front()), XLEN'(exp_rob.pop_front()));
            check_value("cdb_phy", XLEN'(res_phy.pop_front()), XLEN'(exp_phy.pop_front()));
            check_value("cdb_value", res_val.pop_front(), exp_val.pop_front());
        end
        exp_rob.delete();
        exp_phy.delete();
        exp_val.delete();
        res_rob.delete();
        res_phy.delete();
        res_val.delete();
        @(posedge clk);
        #2;
    endtask

    task automatic finish_test(input string name);
        test_count++;
        $display("test %s done with %0d errors", name, err_count - test_err_base);
        test_err_base = err_count;
    endtask

    // ----------------------------------------
    // directed tests
    // ----------------------------------------
    task automatic test_single_multiply();
        write_reg(5'd1, lcg_next());
        write_reg(5'd2, lcg_next());
        issue_op(MUL, 5'd1, 5'd2, 5'd10, 4'd1);
        issue_op(MULHU, 5'd1, 5'd2, 5'd11, 4'd2);
        drain_results();
        finish_test("single multiply");
    endtask

    task automatic test_divide();
        logic [XLEN-1:0] divisor;
        write_reg(5'd3, lcg_next());
        divisor = lcg_next() >> 12;
        write_reg(5'd4, divisor | 32'd1);
        write_reg(5'd5, 32'd0);
        issue_op(DIVU, 5'd3, 5'd4, 5'd12, 4'd3);
        issue_op(REMU, 5'd3, 5'd4, 5'd13, 4'd4);
        issue_op(DIVU, 5'd3, 5'd5, 5'd14, 4'd5);
        issue_op(REMU, 5'd3, 5'd5, 5'd15, 4'd6);
        drain_results();
        finish_test("divide and remainder");
    endtask

    task automatic test_dependency_chain();
        issue_op(MUL, 5'd1, 5'd2, 5'd16, 4'd7);
        issue_op(MUL, 5'd16, 5'd1, 5'd17, 4'd8);
        drain_results();
        finish_test("dependency chain");
    endtask

    // rs1 waits on the divide, rs2 gets its value from a later writeback
    task automatic test_wakeup();
        logic [XLEN-1:0] divisor;
        divisor = lcg_next() >> 20;
        write_reg(5'd6, divisor | 32'd1);
        issue_op(DIVU, 5'd1, 5'd6, 5'd18, 4'd9);
        dispatch_op(MUL, 5'd18, 5'd19, 5'd20, 4'd10);
        write_reg(5'd19, lcg_next());
        predict(MUL, 5'd18, 5'd19, 5'd20, 4'd10);
        drain_results();
        finish_test("wakeup from writeback");
    endtask

    task automatic test_full_burst();
        logic [XLEN-1:0] r;
        stall_seen = 1'b0;
        issue_op(DIVU, 5'd3, 5'd4, 5'd21, 4'd0);
        for (int i = 0; i < DEPTH + 2; i++) begin
            r = lcg_next();
            issue_op(md_op_t'(r[1:0]), PHY_IDX'(1 + r[3:2]), PHY_IDX'(1 + r[5:4]),
                     PHY_IDX'(22 + i), ROB_IDX'(1 + i));
        end
        check_value("in_ready stall seen", XLEN'(stall_seen), 32'd1);
        drain_results();
        finish_test("full station and burst");
    endtask

    initial begin
        rst        = 1'b1;
        in_valid   = 1'b0;
        in_op      = MUL;
        in_rs1_phy = '0;
        in_rs2_phy = '0;
        in_rd_phy  = '0;
        in_rob_id  = '0;
        wb_valid   = 1'b0;
        wb_phy     = '0;
        wb_value   = '0;
        lcg_state  = 32'h5694;
        stall_seen = 1'b0;
        err_count     = 0;
        check_count   = 0;
        test_count    = 0;
        test_err_base = 0;
        for (int i = 0; i < PHY_REGS; i++) begin
            model_regs[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst = 1'b0;

        test_single_multiply();
        test_divide();
        test_dependency_chain();
        test_wakeup();
        test_full_burst();

        $display("%0d tests, %0d checks, %0d errors", test_count, check_count, err_count);
        if (err_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: hdl/md_core.sv
`timescale 1ns/1ps

module md_core #(
    parameter int RS_DEPTH = 8
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       in_valid,
    output logic                       in_ready,
    input  md_pkg::md_op_t             in_op,
    input  logic [md_pkg::PHY_IDX-1:0] in_rs1_phy,
    input  logic [md_pkg::PHY_IDX-1:0] in_rs2_phy,
    input  logic [md_pkg::PHY_IDX-1:0] in_rd_phy,
    input  logic [md_pkg::ROB_IDX-1:0] in_rob_id,
    input  logic                       wb_valid,
    input  logic [md_pkg::PHY_IDX-1:0] wb_phy,
    input  logic [md_pkg::XLEN-1:0]    wb_value,
    output logic                       cdb_valid,
    output logic [md_pkg::PHY_IDX-1:0] cdb_phy,
    output logic [md_pkg::ROB_IDX-1:0] cdb_rob_id,
    output logic [md_pkg::XLEN-1:0]    cdb_value
);
    import md_pkg::*;

    // dispatch to station
    logic               ds_valid, ds_ready;
    md_op_t             ds_op;
    logic [PHY_IDX-1:0] ds_rs1_phy, ds_rs2_phy, ds_rd_phy;
    logic [ROB_IDX-1:0] ds_rob_id;
    logic               ds_rs1_valid, ds_rs2_valid;

    // station to register file
    logic [PHY_IDX-1:0] prf_rs1_phy, prf_rs2_phy;
    logic [XLEN-1:0]    prf_rs1_value, prf_rs2_value;

    // station to unit
    logic               iss_valid, iss_ready;
    md_op_t             iss_op;
    logic [XLEN-1:0]    iss_a, iss_b;
    logic [PHY_IDX-1:0] iss_rd_phy;
    logic [ROB_IDX-1:0] iss_rob_id;

    md_dispatch dispatch_i (.*);

    md_rs #(.RS_DEPTH(RS_DEPTH)) rs_i (.*);

    md_prf prf_i (
        .*,
        .rd1_phy   (prf_rs1_phy),
        .rd2_phy   (prf_rs2_phy),
        .rd1_value (prf_rs1_value),
        .rd2_value (prf_rs2_value)
    );

    md_fu fu_i (.*);

endmodule

// File: hdl/md_dispatch.sv
`timescale 1ns/1ps

module md_dispatch (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       in_valid,
    output logic                       in_ready,
    input  md_pkg::md_op_t             in_op,
    input  logic [md_pkg::PHY_IDX-1:0] in_rs1_phy,
    input  logic [md_pkg::PHY_IDX-1:0] in_rs2_phy,
    input  logic [md_pkg::PHY_IDX-1:0] in_rd_phy,
    input  logic [md_pkg::ROB_IDX-1:0] in_rob_id,
    input  logic                       wb_valid,
    input  logic [md_pkg::PHY_IDX-1:0] wb_phy,
    input  logic                       cdb_valid,
    input  logic [md_pkg::PHY_IDX-1:0] cdb_phy,
    output logic                       ds_valid,
    input  logic                       ds_ready,
    output md_pkg::md_op_t             ds_op,
    output logic [md_pkg::PHY_IDX-1:0] ds_rs1_phy,
    output logic [md_pkg::PHY_IDX-1:0] ds_rs2_phy,
    output logic [md_pkg::PHY_IDX-1:0] ds_rd_phy,
    output logic [md_pkg::ROB_IDX-1:0] ds_rob_id,
    output logic                       ds_rs1_valid,
    output logic                       ds_rs2_valid
);
    import md_pkg::*;

    // one bit per physical register, set while its producer is in flight
    logic pending [PHY_REGS];
    logic accept;
    logic in_rs1_bcast, in_rs2_bcast;
    logic ds_rs1_bcast, ds_rs2_bcast;

    assign in_ready = !ds_valid || ds_ready;
    assign accept   = in_valid && in_ready;

    // same-cycle broadcasts on either cdb slot
    assign in_rs1_bcast = (wb_valid && (wb_phy == in_rs1_phy)) ||
                          (cdb_valid && (cdb_phy == in_rs1_phy));
    assign in_rs2_bcast = (wb_valid && (wb_phy == in_rs2_phy)) ||
                          (cdb_valid && (cdb_phy == in_rs2_phy));
    assign ds_rs1_bcast = (wb_valid && (wb_phy == ds_rs1_phy)) ||
                          (cdb_valid && (cdb_phy == ds_rs1_phy));
    assign ds_rs2_bcast = (wb_valid && (wb_phy == ds_rs2_phy)) ||
                          (cdb_valid && (cdb_phy == ds_rs2_phy));

    // scoreboard: clear on broadcast, then set for the new destination
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < PHY_REGS; i++) begin
                pending[i] <= 1'b0;
            end
        end else begin
            if (wb_valid) begin
                pending[wb_phy] <= 1'b0;
            end
            if (cdb_valid) begin
                pending[cdb_phy] <= 1'b0;
            end
            if (accept) begin
                pending[in_rd_phy] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ds_valid <= 1'b0;
        end else if (in_ready) begin
            ds_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            ds_op        <= in_op;
            ds_rs1_phy   <= in_rs1_phy;
            ds_rs2_phy   <= in_rs2_phy;
            ds_rd_phy    <= in_rd_phy;
            ds_rob_id    <= in_rob_id;
            ds_rs1_valid <= !pending[in_rs1_phy] || in_rs1_bcast;
            ds_rs2_valid <= !pending[in_rs2_phy] || in_rs2_bcast;
        end else begin
            // keep snooping while held
            ds_rs1_valid <= ds_rs1_valid || ds_rs1_bcast;
            ds_rs2_valid <= ds_rs2_valid || ds_rs2_bcast;
        end
    end

endmodule

// File: hdl/md_fu.sv
`timescale 1ns/1ps

module md_fu (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       iss_valid,
    output logic                       iss_ready,
    input  md_pkg::md_op_t             iss_op,
    input  logic [md_pkg::XLEN-1:0]    iss_a,
    input  logic [md_pkg::XLEN-1:0]    iss_b,
    input  logic [md_pkg::PHY_IDX-1:0] iss_rd_phy,
    input  logic [md_pkg::ROB_IDX-1:0] iss_rob_id,
    output logic                       cdb_valid,
    output logic [md_pkg::PHY_IDX-1:0] cdb_phy,
    output logic [md_pkg::ROB_IDX-1:0] cdb_rob_id,
    output logic [md_pkg::XLEN-1:0]    cdb_value
);
    import md_pkg::*;

    // step on which the result is driven onto the cdb
    localparam logic [5:0] MUL_LAST = 6'd1;
    localparam logic [5:0] DIV_LAST = 6'd32;

    logic              busy;
    logic [5:0]        cnt;
    md_op_t            op_r;
    logic [XLEN-1:0]   a_r;
    logic [XLEN-1:0]   b_r;
    logic [2*XLEN-1:0] prod;
    logic [XLEN-1:0]   quo;
    logic [XLEN-1:0]   rem;
    logic [XLEN:0]     shifted;
    logic [XLEN:0]     diff;
    logic              is_div;
    logic              last_step;

    assign iss_ready = !busy;
    assign is_div    = (op_r == DIVU) || (op_r == REMU);
    assign last_step = (cnt == (is_div ? DIV_LAST : MUL_LAST));

    // restoring divide step, one quotient bit per cycle
    assign shifted = {rem, quo[XLEN-1]};
    assign diff    = shifted - {1'b0, b_r};

    // ----------------------------------------
    // control
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            busy      <= 1'b0;
            cdb_valid <= 1'b0;
            cnt       <= '0;
        end else if (!busy) begin
            if (iss_valid) begin
                busy <= 1'b1;
                cnt  <= '0;
            end
        end else if (cdb_valid) begin
            // broadcast held one cycle, then accept again
            busy      <= 1'b0;
            cdb_valid <= 1'b0;
        end else if (last_step) begin
            cdb_valid <= 1'b1;
        end else begin
            cnt <= cnt + 6'd1;
        end
    end

    // ----------------------------------------
    // datapath
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (!busy && iss_valid) begin
            op_r       <= iss_op;
            a_r        <= iss_a;
            b_r        <= iss_b;
            cdb_phy    <= iss_rd_phy;
            cdb_rob_id <= iss_rob_id;
            rem        <= '0;
            quo        <= iss_a;
        end else if (busy && !cdb_valid) begin
            prod <= {{XLEN{1'b0}}, a_r} * {{XLEN{1'b0}}, b_r};
            if (is_div && !last_step) begin
                if (!diff[XLEN]) begin
                    rem <= diff[XLEN-1:0];
                    quo <= {quo[XLEN-2:0], 1'b1};
                end else begin
                    rem <= shifted[XLEN-1:0];
                    quo <= {quo[XLEN-2:0], 1'b0};
                end
            end
            if (last_step) begin
                case (op_r)
                    MUL:     cdb_value <= prod[XLEN-1:0];
                    MULHU:   cdb_value <= prod[2*XLEN-1:XLEN];
                    DIVU:    cdb_value <= quo;
                    default: cdb_value <= rem;
                endcase
            end
        end
    end

endmodule

// File: hdl/md_pkg.sv
package md_pkg;

    // ----------------------------------------
    // datapath and tag widths
    // ----------------------------------------
    localparam int XLEN      = 32;
    localparam int PHY_REGS  = 32;
    localparam int PHY_IDX   = $clog2(PHY_REGS);
    localparam int ROB_IDX   = 4;

    // slot 0 is external writeback, slot 1 the mul/div unit
    localparam int CDB_WIDTH = 2;

    // ----------------------------------------
    // operation codes
    // ----------------------------------------
    // bit 1 set means a divider operation
    typedef enum logic [1:0] {
        MUL   = 2'b00,
        MULHU = 2'b01,
        DIVU  = 2'b10,
        REMU  = 2'b11
    } md_op_t;

    // ----------------------------------------
    // station slot next-state source
    // ----------------------------------------
    typedef enum logic [1:0] {
        PREV    = 2'b00,
        SELF    = 2'b01,
        PUSH_IN = 2'b10
    } rs_update_sel_t;

endpackage

// File: hdl/md_prf.sv
`timescale 1ns/1ps

module md_prf (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       wb_valid,
    input  logic [md_pkg::PHY_IDX-1:0] wb_phy,
    input  logic [md_pkg::XLEN-1:0]    wb_value,
    input  logic                       cdb_valid,
    input  logic [md_pkg::PHY_IDX-1:0] cdb_phy,
    input  logic [md_pkg::XLEN-1:0]    cdb_value,
    input  logic [md_pkg::PHY_IDX-1:0] rd1_phy,
    input  logic [md_pkg::PHY_IDX-1:0] rd2_phy,
    output logic [md_pkg::XLEN-1:0]    rd1_value,
    output logic [md_pkg::XLEN-1:0]    rd2_value
);
    import md_pkg::*;

    logic [XLEN-1:0] regs [PHY_REGS];

    // slot 1 written last so it wins a collision
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < PHY_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (wb_valid) begin
                regs[wb_phy] <= wb_value;
            end
            if (cdb_valid) begin
                regs[cdb_phy] <= cdb_value;
            end
        end
    end

    // write-through bypass, same priority as the write
    always_comb begin
        rd1_value = regs[rd1_phy];
        rd2_value = regs[rd2_phy];
        if (wb_valid && (wb_phy == rd1_phy)) begin
            rd1_value = wb_value;
        end
        if (wb_valid && (wb_phy == rd2_phy)) begin
            rd2_value = wb_value;
        end
        if (cdb_valid && (cdb_phy == rd1_phy)) begin
            rd1_value = cdb_value;
        end
        if (cdb_valid && (cdb_phy == rd2_phy)) begin
            rd2_value = cdb_value;
        end
    end

endmodule

// File: hdl/md_rs.sv
`timescale 1ns/1ps

module md_rs #(
    parameter int RS_DEPTH = 8
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       ds_valid,
    output logic                       ds_ready,
    input  md_pkg::md_op_t             ds_op,
    input  logic [md_pkg::PHY_IDX-1:0] ds_rs1_phy,
    input  logic [md_pkg::PHY_IDX-1:0] ds_rs2_phy,
    input  logic [md_pkg::PHY_IDX-1:0] ds_rd_phy,
    input  logic [md_pkg::ROB_IDX-1:0] ds_rob_id,
    input  logic                       ds_rs1_valid,
    input  logic                       ds_rs2_valid,
    input  logic                       wb_valid,
    input  logic [md_pkg::PHY_IDX-1:0] wb_phy,
    input  logic                       cdb_valid,
    input  logic [md_pkg::PHY_IDX-1:0] cdb_phy,
    output logic [md_pkg::PHY_IDX-1:0] prf_rs1_phy,
    output logic [md_pkg::PHY_IDX-1:0] prf_rs2_phy,
    input  logic [md_pkg::XLEN-1:0]    prf_rs1_value,
    input  logic [md_pkg::XLEN-1:0]    prf_rs2_value,
    output logic                       iss_valid,
    input  logic                       iss_ready,
    output md_pkg::md_op_t             iss_op,
    output logic [md_pkg::XLEN-1:0]    iss_a,
    output logic [md_pkg::XLEN-1:0]    iss_b,
    output logic [md_pkg::PHY_IDX-1:0] iss_rd_phy,
    output logic [md_pkg::ROB_IDX-1:0] iss_rob_id
);
    import md_pkg::*;

    localparam int RS_IDX = (RS_DEPTH > 1) ? $clog2(RS_DEPTH) : 1;
    localparam int TOP_W  = $clog2(RS_DEPTH + 1);

    // age-ordered entries, slot 0 is the oldest
    md_op_t             e_op        [RS_DEPTH];
    logic [PHY_IDX-1:0] e_rs1_phy   [RS_DEPTH];
    logic [PHY_IDX-1:0] e_rs2_phy   [RS_DEPTH];
    logic [PHY_IDX-1:0] e_rd_phy    [RS_DEPTH];
    logic [ROB_IDX-1:0] e_rob_id    [RS_DEPTH];
    logic               e_rs1_valid [RS_DEPTH];
    logic               e_rs2_valid [RS_DEPTH];
    // occupancy, slots below rs_top hold entries
    logic [TOP_W-1:0]   rs_top;

    logic               snoop_valid [CDB_WIDTH];
    logic [PHY_IDX-1:0] snoop_phy   [CDB_WIDTH];

    logic               src1_rdy [RS_DEPTH];
    logic               src2_rdy [RS_DEPTH];
    logic               req      [RS_DEPTH];
    logic               issue_en;
    logic [RS_IDX-1:0]  issue_idx;
    logic               pop_en;
    logic               push_en;
    logic               push_rs1_valid;
    logic               push_rs2_valid;
    logic [TOP_W-1:0]   push_idx;
    logic [TOP_W-1:0]   top_next;
    rs_update_sel_t     update_sel [RS_DEPTH];

    assign snoop_valid[0] = wb_valid;
    assign snoop_phy[0]   = wb_phy;
    assign snoop_valid[1] = cdb_valid;
    assign snoop_phy[1]   = cdb_phy;

    // ----------------------------------------
    // wakeup and oldest-first select
    // ----------------------------------------
    always_comb begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            src1_rdy[i] = e_rs1_valid[i];
            src2_rdy[i] = e_rs2_valid[i];
            for (int k = 0; k < CDB_WIDTH; k++) begin
                if (snoop_valid[k] && (snoop_phy[k] == e_rs1_phy[i])) begin
                    src1_rdy[i] = 1'b1;
                end
                if (snoop_valid[k] && (snoop_phy[k] == e_rs2_phy[i])) begin
                    src2_rdy[i] = 1'b1;
                end
            end
            req[i] = (TOP_W'(i) < rs_top) && src1_rdy[i] && src2_rdy[i];
        end
    end

    // scan downward so the lowest requester wins
    always_comb begin
        issue_en  = 1'b0;
        issue_idx = '0;
        for (int i = RS_DEPTH - 1; i >= 0; i--) begin
            if (req[i]) begin
                issue_en  = 1'b1;
                issue_idx = RS_IDX'(i);
            end
        end
    end

    // incoming micro-op also catches this cycle's broadcasts
    always_comb begin
        push_rs1_valid = ds_rs1_valid;
        push_rs2_valid = ds_rs2_valid;
        for (int k = 0; k < CDB_WIDTH; k++) begin
            if (snoop_valid[k] && (snoop_phy[k] == ds_rs1_phy)) begin
                push_rs1_valid = 1'b1;
            end
            if (snoop_valid[k] && (snoop_phy[k] == ds_rs2_phy)) begin
                push_rs2_valid = 1'b1;
            end
        end
    end

    // ----------------------------------------
    // push, pop and compress control
    // ----------------------------------------
    assign pop_en   = issue_en && iss_ready;
    assign ds_ready = (rs_top < TOP_W'(RS_DEPTH)) || pop_en;
    assign push_en  = ds_valid && ds_ready;
    assign push_idx = pop_en ? rs_top - TOP_W'(1) : rs_top;
    assign top_next = push_en ? push_idx + TOP_W'(1) : push_idx;

    always_comb begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            update_sel[i] = SELF;
            if (pop_en && (RS_IDX'(i) >= issue_idx)) begin
                update_sel[i] = PREV;
            end
            if (push_en && (TOP_W'(i) == push_idx)) begin
                update_sel[i] = PUSH_IN;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rs_top <= '0;
        end else begin
            rs_top <= top_next;
        end
    end

    for (genvar i = 0; i < RS_DEPTH; i++) begin : g_slot
        // top slot has nothing above it and simply empties on a shift
        localparam int SRC = (i < RS_DEPTH - 1) ? i + 1 : i;

        always_ff @(posedge clk) begin
            case (update_sel[i])
                PREV: begin
                    e_op[i]        <= e_op[SRC];
                    e_rs1_phy[i]   <= e_rs1_phy[SRC];
                    e_rs2_phy[i]   <= e_rs2_phy[SRC];
                    e_rd_phy[i]    <= e_rd_phy[SRC];
                    e_rob_id[i]    <= e_rob_id[SRC];
                    e_rs1_valid[i] <= src1_rdy[SRC];
                    e_rs2_valid[i] <= src2_rdy[SRC];
                end
                PUSH_IN: begin
                    e_op[i]        <= ds_op;
                    e_rs1_phy[i]   <= ds_rs1_phy;
                    e_rs2_phy[i]   <= ds_rs2_phy;
                    e_rd_phy[i]    <= ds_rd_phy;
                    e_rob_id[i]    <= ds_rob_id;
                    e_rs1_valid[i] <= push_rs1_valid;
                    e_rs2_valid[i] <= push_rs2_valid;
                end
                default: begin
                    e_rs1_valid[i] <= src1_rdy[i];
                    e_rs2_valid[i] <= src2_rdy[i];
                end
            endcase
        end
    end

    // ----------------------------------------
    // operand read and issue
    // ----------------------------------------
    assign prf_rs1_phy = e_rs1_phy[issue_idx];
    assign prf_rs2_phy = e_rs2_phy[issue_idx];

    assign iss_valid  = issue_en;
    assign iss_op     = e_op[issue_idx];
    assign iss_a      = prf_rs1_value;
    assign iss_b      = prf_rs2_value;
    assign iss_rd_phy = e_rd_phy[issue_idx];
    assign iss_rob_id = e_rob_id[issue_idx];

endmodule

// File: vlog.f
hdl/md_pkg.sv
hdl/md_dispatch.sv
hdl/md_rs.sv
hdl/md_prf.sv
hdl/md_fu.sv
hdl/md_core.sv
bench/md_checker.sv
bench/md_tb.sv
